/* approx_div_unit.f */
verilog/div_pkg.sv
verilog/div_result_if.sv
verilog/divider_array.sv
verilog/div_req_port.sv
verilog/result_fifo.sv
verilog/div_resp_port.sv
verilog/approx_div_unit.sv
tests/approx_div_unit_tb.sv

/* run_sim.sh */
#!/bin/sh
# Builds the testbench with Verilator, runs it and looks for the pass line in the log.
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log
verilator --binary --timing -Wno-fatal --top-module approx_div_unit_tb \
  -f approx_div_unit.f > build.log 2>&1 || { cat build.log; echo "Build failed"; exit 1; }
./obj_dir/Vapprox_div_unit_tb > sim.log 2>&1
cat sim.log
grep -q "^NO ERRORS$" sim.log && echo "Simulation passed" || {
  echo "Simulation failed"; exit 1; }

/* tests/div_vectors.txt */
// One division per line in hex: n(16) _ d(8) _ q(8) _ r(8) _ ovf(4).
// q and r are the approximate array's results with APPROX_DIAGS = 4.
0030_20_01_10_0
0005_09_00_05_0
0064_07_0D_00_0
1234_00_FF_00_1
0000_07_01_00_0
1234_20_91_14_0
00FF_03_57_00_0
1234_12_FF_00_1
00C8_0A_14_00_0
00AB_01_AF_00_0
7FFF_80_FF_7F_0
FFFF_80_FF_00_1
// Stretch with out_ack held off, vectors 12 to 21.
0123_13_0F_00_0
ABCD_F0_B7_3D_0
0FFF_11_F0_0F_0
8000_7F_FF_00_1
00FF_10_0F_0F_0
5000_60_D5_20_0
0000_00_FF_00_1
1000_40_40_00_0
0800_30_2A_20_0
3FFF_50_CC_3F_0
// Remaining cases, some repeated to mix FIFO levels.
9999_A0_F5_79_0
0100_01_FF_00_1
00FF_00_FF_00_1
0064_07_0D_00_0
00AB_01_AF_00_0
0123_13_0F_00_0
00FF_03_57_00_0
0000_07_01_00_0
00C8_0A_14_00_0
ABCD_F0_B7_3D_0

/* tests/approx_div_unit_tb.sv */
module approx_div_unit_tb
  import div_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int NUM_VECTORS    = 32;
  localparam int FIFO_DEPTH     = 4;   // DUT default.
  localparam int BP_FIRST       = 12;  // First vector of the stalled stretch.
  localparam int BP_HOLD_CYCLES = 30;
  localparam int TIMEOUT_CYCLES = NUM_VECTORS * 40 + 100;
  localparam logic [31:0] RAND_SEED = 32'h1123;

  logic       clk;
  logic       rst_n;
  logic       in_req;
  logic       in_ack;
  dividend_t  n;
  divisor_t   d;
  logic       out_req;
  logic       out_ack;
  quotient_t  q;
  remainder_t r;
  logic       ovf;

  // n, d, q, r and ovf of one case in a single word.
  logic [43:0] vec_mem [NUM_VECTORS];

  int acks_seen    = 0;
  int results_done = 0;
  int cycle_count  = 0;

  // Values seen at the previous rising edge.
  logic in_req_prev  = 1'b0;
  logic in_ack_prev  = 1'b0;
  logic out_req_prev = 1'b0;
  logic out_ack_prev = 1'b0;

  approx_div_unit uut (
    .clk    (clk),
    .rst_n  (rst_n),
    .in_req (in_req),
    .in_ack (in_ack),
    .n      (n),
    .d      (d),
    .out_req(out_req),
    .out_ack(out_ack),
    .q      (q),
    .r      (r),
    .ovf    (ovf)
  );

  initial clk = 1'b0;
  always #5 clk = ~clk;

  function automatic dividend_t vector_dividend(input int idx);
    return vec_mem[idx][43:28];
  endfunction

  function automatic divisor_t vector_divisor(input int idx);
    return vec_mem[idx][27:20];
  endfunction

  function automatic quotient_t expected_quotient(input int idx);
    return vec_mem[idx][19:12];
  endfunction

  function automatic remainder_t expected_remainder(input int idx);
    return vec_mem[idx][11:4];
  endfunction

  function automatic logic expected_ovf(input int idx);
    return vec_mem[idx][0];
  endfunction

  task automatic abort_run(input string what);
    $display("%s", what);
    $display("ERRORS FOUND");
    $fatal(1);
  endtask

  task automatic check_quotient(input int idx, input quotient_t got, input quotient_t exp);
    if (got !== exp) begin
      abort_run($sformatf("Mismatch q at vector %0d: got %h, expected %h", idx, got, exp));
    end
  endtask

  task automatic check_remainder(input int idx, input remainder_t got,
                                 input remainder_t exp);
    if (got !== exp) begin
      abort_run($sformatf("Mismatch r at vector %0d: got %h, expected %h", idx, got, exp));
    end
  endtask

  task automatic check_ovf(input int idx, input logic got, input logic exp);
    if (got !== exp) begin
      abort_run($sformatf("Mismatch ovf at vector %0d: got %h, expected %h", idx, got, exp));
    end
  endtask

  task automatic check_handshake(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      abort_run($sformatf("Mismatch %s: got %h, expected %h", name, got, exp));
    end
  endtask

  task automatic check_outputs_idle();
    check_handshake("in_ack", in_ack, 1'b0);
    check_handshake("out_req", out_req, 1'b0);
  endtask

  task automatic check_result(input int idx);
    check_quotient(idx, q, expected_quotient(idx));
    check_remainder(idx, r, expected_remainder(idx));
    check_ovf(idx, ovf, expected_ovf(idx));
  endtask

  // FIFO full plus one result held at the output.
  task automatic check_saturation();
    if (acks_seen - results_done != FIFO_DEPTH + 1) begin
      abort_run($sformatf("Back-pressure left %0d results outstanding instead of %0d",
                          acks_seen - results_done, FIFO_DEPTH + 1));
    end
    if (!in_req || in_ack) begin
      abort_run("The input side was not held off while the FIFO was full");
    end
  endtask

  task automatic load_vectors();
    $readmemh("tests/div_vectors.txt", vec_mem);
    for (int i = 0; i < NUM_VECTORS; i++) begin
      if ($isunknown(vec_mem[i])) begin
        abort_run($sformatf("Vector file has no valid case at index %0d", i));
      end
    end
  endtask

  // Called on a falling edge, returns on one.
  task automatic send_operands(input dividend_t dividend, input divisor_t divisor);
    n      = dividend;
    d      = divisor;
    in_req = 1'b1;
    do @(negedge clk); while (!in_ack);
    in_req = 1'b0;
    do @(negedge clk); while (in_ack);
  endtask

  task automatic run_source();
    for (int k = 0; k < NUM_VECTORS; k++) begin
      repeat ($urandom % 3) @(negedge clk);  // Idle gap between requests.
      send_operands(vector_dividend(k), vector_divisor(k));
    end
  endtask

  task automatic collect_results();
    int unsigned hold;
    for (int k = 0; k < NUM_VECTORS; k++) begin
      while (!out_req) @(negedge clk);
      check_result(k);
      if (k == BP_FIRST) begin
        repeat (BP_HOLD_CYCLES) @(negedge clk);
        check_saturation();
        check_result(k);  // Held data must not move.
      end else begin
        hold = $urandom % 7;
        repeat (hold) @(negedge clk);
      end
      out_ack = 1'b1;
      do @(negedge clk); while (out_req);
      repeat ($urandom % 3) @(negedge clk);  // Sink may release late.
      out_ack = 1'b0;
    end
  endtask

  // Handshake order, seen one edge late through the previous values.
  always @(posedge clk) begin
    if (rst_n) begin
      if (in_ack && !in_ack_prev) begin
        if (!in_req_prev) abort_run("in_ack rose while in_req was low");
        acks_seen++;
        if (acks_seen - results_done > FIFO_DEPTH + 1) begin
          abort_run("More results were accepted than the FIFO and output can hold");
        end
      end
      if (out_req && !out_req_prev && out_ack_prev) begin
        abort_run("out_req rose while out_ack was still high");
      end
      if (out_ack && !out_ack_prev) results_done++;
    end
    in_req_prev  = in_req;
    in_ack_prev  = in_ack;
    out_req_prev = out_req;
    out_ack_prev = out_ack;
  end

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count > TIMEOUT_CYCLES) begin
      abort_run($sformatf("Timeout after %0d cycles with %0d of %0d results received",
                          TIMEOUT_CYCLES, results_done, NUM_VECTORS));
    end
  end

  initial begin
    void'($urandom(RAND_SEED));
    rst_n   = 1'b0;
    in_req  = 1'b0;
    out_ack = 1'b0;
    n       = '0;
    d       = '0;
    load_vectors();
    repeat (3) begin
      @(negedge clk);
      check_outputs_idle();
    end
    rst_n = 1'b1;
    @(negedge clk);
    check_outputs_idle();  // First edge out of reset.
    fork
      run_source();
      collect_results();
    join
    $display("NO ERRORS");
    $finish;
  end

endmodule

/* verilog/approx_div_unit.sv */
module approx_div_unit
  import div_pkg::*;
#(
  parameter int APPROX_DIAGS = 4,
  parameter int FIFO_DEPTH   = 4
) (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       in_req,
  output logic       in_ack,
  input  dividend_t  n,
  input  divisor_t   d,
  output logic       out_req,
  input  logic       out_ack,
  output quotient_t  q,
  output remainder_t r,
  output logic       ovf
);

  div_result_if push_bus ();
  div_result_if pop_bus ();

  div_req_port #(
    .APPROX_DIAGS(APPROX_DIAGS)
  ) u_req (
    .clk   (clk),
    .rst_n (rst_n),
    .in_req(in_req),
    .in_ack(in_ack),
    .n     (n),
    .d     (d),
    .push  (push_bus.source)
  );

  result_fifo #(
    .FIFO_DEPTH(FIFO_DEPTH)
  ) u_fifo (
    .clk  (clk),
    .rst_n(rst_n),
    .wr   (push_bus.sink),
    .rd   (pop_bus.source)
  );

  div_resp_port u_resp (
    .clk    (clk),
    .rst_n  (rst_n),
    .pop    (pop_bus.sink),
    .out_req(out_req),
    .out_ack(out_ack),
    .q      (q),
    .r      (r),
    .ovf    (ovf)
  );

endmodule

/* verilog/div_resp_port.sv */
module div_resp_port
  import div_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  div_result_if.sink pop,
  output logic       out_req,
  input  logic       out_ack,
  output quotient_t  q,
  output remainder_t r,
  output logic       ovf
);

  hs_state_t   state;
  div_result_t held;  // Stable for the whole output cycle.

  assign pop.ready = (state == HS_IDLE);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state   <= HS_IDLE;
      out_req <= 1'b0;
    end else begin
      case (state)
        HS_IDLE: begin
          if (pop.valid) begin
            out_req <= 1'b1;
            state   <= HS_ACK;
          end
        end
        HS_ACK: begin
          if (out_ack) begin
            out_req <= 1'b0;
            state   <= HS_WAIT_LOW;
          end
        end
        HS_WAIT_LOW: begin
          if (!out_ack) state <= HS_IDLE;  // Sink has finished.
        end
        default: state <= HS_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (pop.valid && pop.ready) held <= pop.data;
  end

  assign q   = held.q;
  assign r   = held.r;
  assign ovf = held.ovf;

endmodule

/* verilog/result_fifo.sv */
module result_fifo
  import div_pkg::*;
#(
  parameter int FIFO_DEPTH = 4  // Power of two, at least 2.
) (
  input  logic         clk,
  input  logic         rst_n,
  div_result_if.sink   wr,
  div_result_if.source rd
);

  localparam int AW = $clog2(FIFO_DEPTH);

  div_result_t mem [FIFO_DEPTH];

  // One extra wrap bit on each pointer.
  logic [AW:0] wptr;
  logic [AW:0] rptr;
  logic        full;
  logic        empty;
  logic        do_push;
  logic        do_pop;

  assign empty = (wptr == rptr);
  assign full  = (wptr[AW] != rptr[AW]) && (wptr[AW-1:0] == rptr[AW-1:0]);

  assign wr.ready = ~full;
  assign rd.valid = ~empty;
  assign rd.data  = mem[rptr[AW-1:0]];

  assign do_push = wr.valid & wr.ready;
  assign do_pop  = rd.valid & rd.ready;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wptr <= '0;
      rptr <= '0;
    end else begin
      if (do_push) wptr <= wptr + 1'b1;
      if (do_pop) rptr <= rptr + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wptr[AW-1:0]] <= wr.data;
    end
  end

endmodule

/* verilog/div_req_port.sv */
module div_req_port
  import div_pkg::*;
#(
  parameter int APPROX_DIAGS = 4
) (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                in_req,
  output logic                in_ack,
  input  dividend_t           n,
  input  divisor_t            d,
  div_result_if.source        push
);

  hs_state_t   state;
  quotient_t   arr_q;
  remainder_t  arr_r;
  logic        ovf;
  div_result_t result;

  divider_array #(
    .APPROX_DIAGS(APPROX_DIAGS)
  ) u_array (
    .n(n),
    .d(d),
    .q(arr_q),
    .r(arr_r)
  );

  // Quotient would need more than 8 bits.
  assign ovf = (d == '0) || (n[15:8] >= d);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state  <= HS_IDLE;
      in_ack <= 1'b0;
    end else begin
      case (state)
        HS_IDLE: begin
          if (in_req) state <= HS_ACK;
        end
        HS_ACK: begin
          if (push.ready) begin  // Push done, acknowledge.
            in_ack <= 1'b1;
            state  <= HS_WAIT_LOW;
          end
        end
        HS_WAIT_LOW: begin
          if (!in_req) begin
            in_ack <= 1'b0;
            state  <= HS_IDLE;
          end
        end
        default: state <= HS_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == HS_IDLE && in_req) begin
      result.q   <= ovf ? 8'hFF : arr_q;
      result.r   <= ovf ? 8'h00 : arr_r;
      result.ovf <= ovf;
    end
  end

  assign push.valid = (state == HS_ACK);
  assign push.data  = result;

endmodule

/* verilog/divider_array.sv */
module divider_array
  import div_pkg::*;
#(
  parameter int APPROX_DIAGS = 4
) (
  input  dividend_t  n,
  input  divisor_t   d,
  output quotient_t  q,
  output remainder_t r
);

  // Row i yields quotient bit i, rows are evaluated from row 7 down.
  // Column j subtracts divisor bit j.
  for (genvar i = 0; i < 8; i++) begin : g_row
    logic qb;   // Quotient bit of this row.
    logic hi;   // Bit above the 8 columns.

    for (genvar j = 0; j < 8; j++) begin : g_col
      logic x;
      logic b;
      logic bo;
      logic diff;
      logic p;  // Partial remainder bit after the select.

      if (j == 0) begin : g_lsb
        assign x = n[i];
        assign b = 1'b0;
      end else if (i == 7) begin : g_top
        assign x = n[7+j];
        assign b = g_row[i].g_col[j-1].bo;
      end else begin : g_inner
        assign x = g_row[i+1].g_col[j-1].p;
        assign b = g_row[i].g_col[j-1].bo;
      end

      if (i + j < APPROX_DIAGS) begin : g_approx
        // Cheap cell in the lower-left triangle.
        assign diff = x & ~d[j] & ~b;
        assign bo   = (~x & d[j]) | (x & d[j] & b);
      end else begin : g_exact
        assign diff = x ^ d[j] ^ b;
        assign bo   = (~x & d[j]) | (~(x ^ d[j]) & b);
      end

      assign p = qb ? diff : x;  // Restore on a failed subtract.
    end

    if (i == 7) begin : g_hi_top
      assign hi = n[15];
    end else begin : g_hi_inner
      assign hi = g_row[i+1].g_col[7].p;
    end

    assign qb   = hi | ~g_col[7].bo;
    assign q[i] = qb;
  end

  // Remainder is what row 0 leaves.
  for (genvar j = 0; j < 8; j++) begin : g_rem
    assign r[j] = g_row[0].g_col[j].p;
  end

endmodule

/* verilog/div_result_if.sv */
interface div_result_if
  import div_pkg::*;
();

  logic        valid;
  logic        ready;
  div_result_t data;

  // Transfer on any edge with valid and ready both high.
  modport source (
    output valid,
    output data,
    input  ready
  );

  modport sink (
    input  valid,
    input  data,
    output ready
  );

endinterface

/* verilog/div_pkg.sv */
package div_pkg;

  // Operand and result widths of the 16 by 8 divider.
  typedef logic [15:0] dividend_t;
  typedef logic [7:0]  divisor_t;
  typedef logic [7:0]  quotient_t;
  typedef logic [7:0]  remainder_t;

  // One finished division as it travels through the FIFO.
  typedef struct packed {
    quotient_t  q;
    remainder_t r;
    logic       ovf;  // Quotient does not fit.
  } div_result_t;

  // Four-phase handshake side.
  typedef enum logic [1:0] {
    HS_IDLE,
    HS_ACK,
    HS_WAIT_LOW
  } hs_state_t;

endpackage
